/* sd_cmd_pkg.sv */
package sd_cmd_pkg;

	////////////////////
	// Frame geometry and timing
	////////////////////

	// Command frame and short response share one length
	localparam int CMD_FRAME_BITS = 48;

	// Idle cycles before a response wait gives up
	// Well short of the half-second card limit
	localparam int TIMEOUT_CYCLES = 1000;

	// Width of the idle counter, holds TIMEOUT_CYCLES itself
	localparam int TIMEOUT_BITS = $clog2(TIMEOUT_CYCLES + 1);

	////////////////////
	// Field types
	////////////////////

	typedef logic [5:0]  cmd_index_t;
	typedef logic [31:0] cmd_arg_t;
	typedef logic [6:0]  crc7_t;
	typedef logic [7:0]  bit_count_t;

	// x^7 + x^3 + 1
	localparam crc7_t CRC_POLY = 7'h09;

	// Expected response kind
	// Code 2'b10 is unused here (long R2 response)
	typedef enum logic [1:0] {
		RESP_NONE = 2'b00,
		RESP_R1   = 2'b01,
		RESP_R1B  = 2'b11
	} resp_kind_e;

	// Completion code, TIMEOUT doubles as the idle value
	typedef enum logic [1:0] {
		ERR_TIMEOUT = 2'b00,
		ERR_OKAY    = 2'b01,
		ERR_BADCRC  = 2'b10,
		ERR_FRAME   = 2'b11
	} err_code_e;

	// Controller request, 41 bits
	typedef struct packed {
		resp_kind_e kind;
		cmd_index_t index;
		cmd_arg_t   arg;
		logic       dbl;
	} cmd_req_t;

	// Fields pulled out of a short response, 38 bits
	typedef struct packed {
		cmd_index_t index;
		cmd_arg_t   arg;
	} cmd_resp_t;

	////////////////////
	// CRC7 helpers
	////////////////////

	// One bit into the remainder, MSB first
	function automatic crc7_t crc7_step(input crc7_t fill, input logic din);
		crc7_t shifted;
		shifted = {fill[5:0], 1'b0};
		// Feedback when outgoing MSB differs from the data bit
		if (fill[6] ^ din)
			return shifted ^ CRC_POLY;
		return shifted;
	endfunction

	// CRC7 over start, direction, index and argument
	function automatic crc7_t crc7_frame(input logic [39:0] prefix);
		crc7_t fill;
		fill = '0;
		for (int i = 39; i >= 0; i--)
			fill = crc7_step(fill, prefix[i]);
		return fill;
	endfunction

endpackage

/* sd_cmd_tx.sv */
`timescale 1ns/1ps

module sd_cmd_tx (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_ckstb,
	input  logic                 i_accept,
	input  sd_cmd_pkg::cmd_req_t i_req,
	output logic                 o_tx_active,
	output logic                 o_last_strobe,
	output logic                 o_cmd_en,
	output logic [1:0]           o_cmd_data
);

	// Outgoing frame, MSB leaves first
	logic [sd_cmd_pkg::CMD_FRAME_BITS-1:0] tx_sreg;
	// Bits still to send
	logic [5:0]  tx_left;
	// Start bit, host direction bit, index, argument
	logic [39:0] prefix;
	// Bits consumed per strobe
	logic [5:0]  step;

	assign prefix = {2'b01, i_req.index, i_req.arg};
	assign step = i_req.dbl ? 6'd2 : 6'd1;

	////////////////////
	// Bit counter
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			tx_left <= '0;
		else if (i_accept)
			tx_left <= 6'(sd_cmd_pkg::CMD_FRAME_BITS);
		else if (i_ckstb && (tx_left != '0))
			tx_left <= tx_left - step;
	end

	assign o_tx_active = (tx_left != '0);

	// Strobe that drains the count
	// Sequencer ends no-response commands here
	assign o_last_strobe = i_ckstb && (tx_left == step);

	////////////////////
	// Shift register
	////////////////////

	always_ff @(posedge i_clk)
	begin
		// Idle line sits high
		if (i_reset)
			tx_sreg <= '1;
		else if (i_accept)
			tx_sreg <= {prefix, sd_cmd_pkg::crc7_frame(prefix), 1'b1};
		else if (i_ckstb && o_tx_active)
		begin
			// Back-fill with ones so the line idles at 11
			if (i_req.dbl)
				tx_sreg <= {tx_sreg[45:0], 2'b11};
			else
				tx_sreg <= {tx_sreg[46:0], 1'b1};
		end
	end

	// Driver enabled only while bits remain
	assign o_cmd_en = o_tx_active;
	// First bit on bit 1
	assign o_cmd_data = tx_sreg[47:46];

	// Count bounded, and even throughout a double-rate frame
	// Relies on the sequencer holding the latched request steady
	a_tx_count: assert property (@(posedge i_clk) disable iff (i_reset)
		(tx_left <= 6'(sd_cmd_pkg::CMD_FRAME_BITS)) && (!i_req.dbl || !tx_left[0]));

endmodule

/* sd_cmd_rx.sv */
`timescale 1ns/1ps

module sd_cmd_rx (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_accept,
	input  sd_cmd_pkg::cmd_req_t  i_req,
	input  logic                  i_listen,
	input  logic [1:0]            i_cmd_strb,
	input  logic [1:0]            i_cmd_data,
	output logic                  o_bit_seen,
	output logic                  o_rx_done,
	output logic                  o_crc_err,
	output logic                  o_frame_err,
	output sd_cmd_pkg::cmd_resp_t o_resp
);

	// Bits received so far
	sd_cmd_pkg::bit_count_t bit_cnt;
	sd_cmd_pkg::bit_count_t cnt_next;
	// One-based frame positions of the first and second incoming bit
	sd_cmd_pkg::bit_count_t pos_a;
	sd_cmd_pkg::bit_count_t pos_b;
	sd_cmd_pkg::bit_count_t frame_len;
	// Running remainder over positions 2 to 40
	sd_cmd_pkg::crc7_t      crc_q;
	sd_cmd_pkg::crc7_t      crc_next;
	// Whole response, first bit ends up at the MSB
	logic [sd_cmd_pkg::CMD_FRAME_BITS-1:0] rx_sreg;
	logic take_a;
	logic take_b;
	logic bad_a;
	logic bad_b;

	assign frame_len = sd_cmd_pkg::bit_count_t'(sd_cmd_pkg::CMD_FRAME_BITS);

	// Any strobe restarts the sequencer's idle counter
	assign o_bit_seen = |i_cmd_strb;

	////////////////////
	// Bit acceptance
	////////////////////

	assign pos_a = bit_cnt + 8'd1;
	assign pos_b = bit_cnt + 8'd2;

	// First bit, stops once the frame is full
	assign take_a = i_listen && i_cmd_strb[1] && (bit_cnt < frame_len);
	// Second bit only in double-rate mode and never past bit 48
	assign take_b = take_a && i_cmd_strb[0] && i_req.dbl && (pos_a < frame_len);

	assign cnt_next = bit_cnt + sd_cmd_pkg::bit_count_t'(take_a)
		+ sd_cmd_pkg::bit_count_t'(take_b);

	// CRC covers direction bit, index and argument
	// Start bit is skipped since a zero into a zero fill changes nothing
	always_comb
	begin
		crc_next = crc_q;
		if (take_a && (pos_a >= 8'd2) && (pos_a <= 8'd40))
			crc_next = sd_cmd_pkg::crc7_step(crc_next, i_cmd_data[1]);
		if (take_b && (pos_b >= 8'd2) && (pos_b <= 8'd40))
			crc_next = sd_cmd_pkg::crc7_step(crc_next, i_cmd_data[0]);
	end

	// Framing
	// Start and direction bits must be 0, end bit must be 1
	assign bad_a = take_a && (((pos_a <= 8'd2) && i_cmd_data[1])
		|| ((pos_a == frame_len) && !i_cmd_data[1]));
	assign bad_b = take_b && (((pos_b <= 8'd2) && i_cmd_data[0])
		|| ((pos_b == frame_len) && !i_cmd_data[0]));

	////////////////////
	// State
	////////////////////

	// Count and CRC restart whenever the sequencer stops listening
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_listen)
		begin
			bit_cnt <= '0;
			crc_q   <= '0;
		end
		else
		begin
			bit_cnt <= cnt_next;
			crc_q   <= crc_next;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (take_b)
			rx_sreg <= {rx_sreg[45:0], i_cmd_data};
		else if (take_a)
			rx_sreg <= {rx_sreg[46:0], i_cmd_data[1]};
	end

	// Sticky until the next command is accepted
	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_accept)
			o_frame_err <= 1'b0;
		else if (bad_a || bad_b)
			o_frame_err <= 1'b1;
	end

	// One pulse, on the cycle the count lands on 48
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_rx_done <= 1'b0;
		else
			o_rx_done <= take_a && (cnt_next == frame_len);
	end

	////////////////////
	// Outputs
	////////////////////

	// Only meaningful alongside o_rx_done
	assign o_crc_err = (crc_q != rx_sreg[7:1]);

	// Index in bits 45:40, argument in 39:8
	// Shifting stops at 48 so both stay frozen
	assign o_resp = sd_cmd_pkg::cmd_resp_t'(rx_sreg[45:8]);

	a_rx_count: assert property (@(posedge i_clk) disable iff (i_reset)
		bit_cnt <= frame_len);

endmodule

/* sd_cmd_seq.sv */
`timescale 1ns/1ps

module sd_cmd_seq (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_ckstb,
	input  logic                  i_cmd_request,
	input  sd_cmd_pkg::cmd_req_t  i_req,
	output logic                  o_accept,
	output sd_cmd_pkg::cmd_req_t  o_req,
	input  logic                  i_tx_active,
	input  logic                  i_last_strobe,
	input  logic                  i_bit_seen,
	input  logic                  i_rx_done,
	input  logic                  i_crc_err,
	input  logic                  i_frame_err,
	output logic                  o_listen,
	output logic                  o_busy,
	output logic                  o_done,
	output logic                  o_err,
	output sd_cmd_pkg::err_code_e o_err_code
);

	logic busy_q;
	// Response expected
	// Set through transmit and the wait
	logic waiting;
	sd_cmd_pkg::cmd_req_t req_q;
	logic [sd_cmd_pkg::TIMEOUT_BITS-1:0] idle_cnt;
	logic timeout;
	logic no_resp_end;

	////////////////////
	// Acceptance
	////////////////////

	// Requests land only on a strobe cycle
	assign o_busy = busy_q || !i_ckstb;
	assign o_accept = i_cmd_request && !o_busy;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			req_q <= '0;
		else if (o_accept)
			req_q <= i_req;
	end

	// Live request on the accept cycle so the transmitter can load the frame
	assign o_req = o_accept ? i_req : req_q;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			busy_q  <= 1'b0;
			waiting <= 1'b0;
		end
		else if (o_accept)
		begin
			busy_q  <= 1'b1;
			waiting <= (i_req.kind != sd_cmd_pkg::RESP_NONE);
		end
		else if (o_done)
		begin
			busy_q  <= 1'b0;
			waiting <= 1'b0;
		end
	end

	// Receive window opens once the last bit is out
	assign o_listen = waiting && !i_tx_active;

	////////////////////
	// Response timeout
	////////////////////

	// Restarts from zero once the limit is hit
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !o_listen || i_bit_seen || timeout)
			idle_cnt <= '0;
		else
			idle_cnt <= idle_cnt + 1'b1;
	end

	assign timeout = o_listen
		&& (idle_cnt == sd_cmd_pkg::TIMEOUT_BITS'(sd_cmd_pkg::TIMEOUT_CYCLES));

	// No response expected
	assign no_resp_end = i_last_strobe && (req_q.kind == sd_cmd_pkg::RESP_NONE);

	////////////////////
	// Completion
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_done <= 1'b0;
		else
			o_done <= timeout || i_rx_done || no_resp_end;
	end

	// Back to the idle code at acceptance
	// CRC error outranks frame error
	always_ff @(posedge i_clk)
	begin
		if (i_reset || o_accept)
		begin
			o_err      <= 1'b0;
			o_err_code <= sd_cmd_pkg::ERR_TIMEOUT;
		end
		else if (timeout)
		begin
			o_err      <= 1'b1;
			o_err_code <= sd_cmd_pkg::ERR_TIMEOUT;
		end
		else if (i_rx_done)
		begin
			o_err <= i_crc_err || i_frame_err;
			if (i_crc_err)
				o_err_code <= sd_cmd_pkg::ERR_BADCRC;
			else if (i_frame_err)
				o_err_code <= sd_cmd_pkg::ERR_FRAME;
			else
				o_err_code <= sd_cmd_pkg::ERR_OKAY;
		end
	end

	a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
		o_done |=> !o_done);

	a_no_err_tx: assert property (@(posedge i_clk) disable iff (i_reset)
		i_tx_active |-> !o_err);

endmodule

/* sd_cmd.sv */
`timescale 1ns/1ps

module sd_cmd (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_ckstb,
	// Controller side
	input  logic                  i_cmd_request,
	input  sd_cmd_pkg::cmd_req_t  i_req,
	output logic                  o_busy,
	output logic                  o_done,
	output logic                  o_err,
	output sd_cmd_pkg::err_code_e o_err_code,
	output sd_cmd_pkg::cmd_resp_t o_resp,
	// Front end
	output logic                  o_cmd_en,
	output logic [1:0]            o_cmd_data,
	input  logic [1:0]            i_cmd_strb,
	input  logic [1:0]            i_cmd_data
);

	logic                 accept;
	sd_cmd_pkg::cmd_req_t req;
	logic                 tx_active;
	logic                 last_strobe;
	logic                 listen;
	logic                 bit_seen;
	logic                 rx_done;
	logic                 crc_err;
	logic                 frame_err;

	////////////////////
	// Command out
	////////////////////

	sd_cmd_tx tx_i (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_ckstb       (i_ckstb),
		.i_accept      (accept),
		.i_req         (req),
		.o_tx_active   (tx_active),
		.o_last_strobe (last_strobe),
		.o_cmd_en      (o_cmd_en),
		.o_cmd_data    (o_cmd_data)
	);

	////////////////////
	// Response in
	////////////////////

	sd_cmd_rx rx_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_accept    (accept),
		.i_req       (req),
		.i_listen    (listen),
		.i_cmd_strb  (i_cmd_strb),
		.i_cmd_data  (i_cmd_data),
		.o_bit_seen  (bit_seen),
		.o_rx_done   (rx_done),
		.o_crc_err   (crc_err),
		.o_frame_err (frame_err),
		.o_resp      (o_resp)
	);

	// Busy, timeout and completion
	sd_cmd_seq seq_i (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_ckstb       (i_ckstb),
		.i_cmd_request (i_cmd_request),
		.i_req         (i_req),
		.o_accept      (accept),
		.o_req         (req),
		.i_tx_active   (tx_active),
		.i_last_strobe (last_strobe),
		.i_bit_seen    (bit_seen),
		.i_rx_done     (rx_done),
		.i_crc_err     (crc_err),
		.i_frame_err   (frame_err),
		.o_listen      (listen),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_err         (o_err),
		.o_err_code    (o_err_code)
	);

endmodule

/* tb_sd_cmd.sv */
`timescale 1ns/1ps

module tb_sd_cmd;

	logic                  i_clk = 1'b0;
	logic                  i_reset;
	logic                  i_ckstb;
	logic                  i_cmd_request;
	sd_cmd_pkg::cmd_req_t  i_req;
	logic                  o_busy;
	logic                  o_done;
	logic                  o_err;
	sd_cmd_pkg::err_code_e o_err_code;
	sd_cmd_pkg::cmd_resp_t o_resp;
	logic                  o_cmd_en;
	logic [1:0]            o_cmd_data;
	logic [1:0]            i_cmd_strb;
	logic [1:0]            i_cmd_data;

	int          err_count = 0;
	int          check_count = 0;
	logic [31:0] rnd;
	// Last completion seen on the falling edge
	int          done_cnt = 0;
	logic        done_err;
	logic [1:0]  done_code;
	logic [37:0] done_resp;

	sd_cmd dut_i (.*);

	// 8 ns clock
	// Command strobe every other cycle
	always #4 i_clk = ~i_clk;

	always @(posedge i_clk)
	begin
		#1;
		i_ckstb = ~i_ckstb;
	end

	always @(negedge i_clk)
	begin
		if (o_done)
		begin
			done_cnt = done_cnt + 1;
			done_err = o_err;
			done_code = o_err_code;
			done_resp = o_resp;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		check_count++;
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			err_count++;
		end
	endtask

	// Generator x^7 + x^3 + 1
	// Written out as taps
	function automatic logic [6:0] calc_crc7(input logic [39:0] bits);
		logic [6:0] c;
		logic       fb;
		c = '0;
		for (int i = 39; i >= 0; i--)
		begin
			fb = c[6] ^ bits[i];
			c = {c[5:3], c[2] ^ fb, c[1:0], fb};
		end
		return c;
	endfunction

	// Host command with start 0 then direction 1
	function automatic logic [47:0] cmd_frame(input logic [5:0] idx, input logic [31:0] arg);
		return {2'b01, idx, arg, calc_crc7({2'b01, idx, arg}), 1'b1};
	endfunction

	task automatic issue_command(input sd_cmd_pkg::resp_kind_e kind, input logic dbl,
		input logic [5:0] idx, input logic [31:0] arg);
		int i;
		@(posedge i_clk);
		#1;
		i_req.kind = kind;
		i_req.dbl = dbl;
		i_req.index = idx;
		i_req.arg = arg;
		i_cmd_request = 1'b1;
		// Accepted on the next edge once busy is low
		for (i = 0; i < 10; i++)
		begin
			@(negedge i_clk);
			if (!o_busy)
				break;
		end
		if (i == 10)
		begin
			$display("Request was never accepted");
			err_count++;
		end
		@(posedge i_clk);
		#1;
		i_cmd_request = 1'b0;
	endtask

	// Card side sampling of the line on every strobe while the driver is on
	task automatic capture_frame(input logic dbl, output logic [47:0] frame,
		output int strobes);
		int i;
		frame = '0;
		strobes = 0;
		for (i = 0; i < 200; i++)
		begin
			@(negedge i_clk);
			if (!o_cmd_en)
				break;
			if (i_ckstb)
			begin
				strobes++;
				if (dbl)
					frame = {frame[45:0], o_cmd_data};
				else
					frame = {frame[46:0], o_cmd_data[1]};
			end
		end
		if (i == 200)
		begin
			$display("Timeout: command line driver stayed enabled");
			err_count++;
		end
	endtask

	// Card answer after a short pause
	// One or two bits per cycle
	// Fault 1 flips a CRC bit
	// Fault 2 clears the end bit
	task automatic card_reply(input logic dbl, input logic [5:0] idx,
		input logic [31:0] arg, input int fault);
		logic [47:0] frame;
		frame = {2'b00, idx, arg, calc_crc7({2'b00, idx, arg}), 1'b1};
		if (fault == 1)
			frame[4] = ~frame[4];
		if (fault == 2)
			frame[0] = 1'b0;
		repeat (3) @(posedge i_clk);
		for (int i = 0; i < (dbl ? 24 : 48); i++)
		begin
			#1;
			if (dbl)
			begin
				i_cmd_strb = 2'b11;
				i_cmd_data = frame[47 - 2 * i -: 2];
			end
			else
			begin
				i_cmd_strb = 2'b10;
				i_cmd_data = {frame[47 - i], 1'b0};
			end
			@(posedge i_clk);
		end
		#1;
		i_cmd_strb = 2'b00;
		i_cmd_data = 2'b11;
	endtask

	task automatic wait_for_done(input int start, input int limit, output logic ok);
		for (int i = 0; i < limit; i++)
		begin
			@(posedge i_clk);
			if (done_cnt != start)
				break;
		end
		ok = (done_cnt != start);
		if (!ok)
		begin
			$display("Timeout: no completion pulse after %0d cycles", limit);
			err_count++;
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	// No-response command with the frame on the line and a clean completion
	task automatic transmit_frame(input logic dbl);
		logic [47:0] frame;
		int          strobes;
		int          start;
		logic        ok;
		rnd = $urandom;
		start = done_cnt;
		issue_command(sd_cmd_pkg::RESP_NONE, dbl, rnd[5:0], $urandom);
		capture_frame(dbl, frame, strobes);
		check_value("tx frame", frame, cmd_frame(i_req.index, i_req.arg));
		check_value("tx strobes", strobes, dbl ? 24 : 48);
		check_value("idle o_cmd_data", o_cmd_data, 2'b11);
		wait_for_done(start, 20, ok);
		check_value("o_err", done_err, 1'b0);
		check_value("o_err_code", done_code, sd_cmd_pkg::ERR_TIMEOUT);
		repeat (4) @(posedge i_clk);
		check_value("done pulses", done_cnt - start, 1);
	endtask

	task automatic answer_command(input logic dbl, input sd_cmd_pkg::resp_kind_e kind,
		input int fault, input logic exp_err, input logic [1:0] exp_code);
		logic [47:0] frame;
		logic [5:0]  ridx;
		logic [31:0] rarg;
		int          strobes;
		int          start;
		logic        ok;
		rnd = $urandom;
		ridx = rnd[13:8];
		rarg = $urandom;
		start = done_cnt;
		issue_command(kind, dbl, rnd[5:0], $urandom);
		capture_frame(dbl, frame, strobes);
		check_value("tx frame", frame, cmd_frame(i_req.index, i_req.arg));
		check_value("tx strobes", strobes, dbl ? 24 : 48);
		// Nothing may complete before the card answers
		check_value("early done", done_cnt - start, 0);
		card_reply(dbl, ridx, rarg, fault);
		wait_for_done(start, 100, ok);
		if (ok)
		begin
			check_value("o_err", done_err, exp_err);
			check_value("o_err_code", done_code, exp_code);
			check_value("o_resp", done_resp, {ridx, rarg});
		end
		repeat (4) @(posedge i_clk);
		check_value("done pulses", done_cnt - start, 1);
	endtask

	// R1b with no answer at all
	task automatic silent_card();
		logic [47:0] frame;
		int          strobes;
		int          start;
		int          i;
		logic        ok;
		rnd = $urandom;
		start = done_cnt;
		issue_command(sd_cmd_pkg::RESP_R1B, 1'b0, rnd[5:0], $urandom);
		capture_frame(1'b0, frame, strobes);
		check_value("tx frame", frame, cmd_frame(i_req.index, i_req.arg));
		check_value("tx strobes", strobes, 48);
		wait_for_done(start, sd_cmd_pkg::TIMEOUT_CYCLES + 20, ok);
		check_value("o_err", done_err, 1'b1);
		check_value("o_err_code", done_code, sd_cmd_pkg::ERR_TIMEOUT);
		for (i = 0; i < 4; i++)
		begin
			@(negedge i_clk);
			if (!o_busy)
				break;
		end
		if (i == 4)
		begin
			$display("Busy stayed high after the timeout completion");
			err_count++;
		end
	endtask

	initial
	begin
		rnd = $urandom(47);
		i_reset = 1'b1;
		i_ckstb = 1'b0;
		i_cmd_request = 1'b0;
		i_req = '0;
		i_cmd_strb = 2'b00;
		i_cmd_data = 2'b11;
		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		transmit_frame(1'b0);
		transmit_frame(1'b1);
		answer_command(1'b0, sd_cmd_pkg::RESP_R1, 0, 1'b0, sd_cmd_pkg::ERR_OKAY);
		answer_command(1'b1, sd_cmd_pkg::RESP_R1B, 0, 1'b0, sd_cmd_pkg::ERR_OKAY);
		answer_command(1'b0, sd_cmd_pkg::RESP_R1, 1, 1'b1, sd_cmd_pkg::ERR_BADCRC);
		answer_command(1'b1, sd_cmd_pkg::RESP_R1, 2, 1'b1, sd_cmd_pkg::ERR_FRAME);
		silent_card();

		repeat (4) @(posedge i_clk);
		$display("Checks run: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* project.f */
sd_cmd_pkg.sv
sd_cmd_tx.sv
sd_cmd_rx.sv
sd_cmd_seq.sv
sd_cmd.sv
tb_sd_cmd.sv

/* Makefile */
SRCS = sd_cmd_pkg.sv sd_cmd_tx.sv sd_cmd_rx.sv sd_cmd_seq.sv sd_cmd.sv tb_sd_cmd.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_sd_cmd: $(SRCS) project.f
	verilator --binary --assert -Wno-fatal -f project.f --top-module tb_sd_cmd -o Vtb_sd_cmd

run: obj_dir/Vtb_sd_cmd
	./obj_dir/Vtb_sd_cmd | tee sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
